/* rtl/corePkg.sv */
// Core package
// Widths, RV32I encodings and stage payload types for the five-stage integer core
`default_nettype none

package corePkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

    // Major opcodes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // funct3 codes, the branch codes reuse the ALU encodings
    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Or  = 3'b110;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluOpT;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        aluOpT aluOp;
        logic  useImm;
        logic  isBranch;
        logic  branchNe;
        logic  isJal;
        logic  resultIsLink;
    } deCtrlT;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     rs1Val;
        logic [xlen-1:0]     rs2Val;
        logic [xlen-1:0]     imm;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rd;
        deCtrlT              ctrl;
    } exPayloadT;

    // Shared by the memory and writeback registers
    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic                regWrite;
        logic [xlen-1:0]     result;
    } wbPayloadT;

endpackage

`default_nettype wire

/* rtl/pipeReg.sv */
// Pipeline register
// Carries one payload between stages with a valid bit that reset and flush clear
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    flush_i,
    input  logic    valid_i,
    input  payloadT data_i,
    output logic    valid_o,
    output payloadT data_o
);

    // A flushed slot becomes a bubble
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        data_o <= data_i;
    end

endmodule

`default_nettype wire

/* rtl/fetchStage.sv */
// Fetch stage
// Program counter and four-phase req/ack handshake to the instruction memory
`default_nettype none

module fetchStage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     imemAck_i,
    input  logic [corePkg::xlen-1:0] imemInstr_i,
    input  logic                     redirect_i,
    input  logic [corePkg::xlen-1:0] redirectPc_i,
    output logic                     imemReq_o,
    output logic [corePkg::xlen-1:0] imemAddr_o,
    output logic                     instrValid_o,
    output logic [corePkg::xlen-1:0] instr_o,
    output logic [corePkg::xlen-1:0] instrPc_o
);

    logic                     reqQ;
    logic                     discardQ;
    logic [corePkg::xlen-1:0] pcQ;
    logic [corePkg::xlen-1:0] addrQ;
    logic [corePkg::xlen-1:0] pcNext;
    logic                     capture;
    logic                     raise;

    assign capture = reqQ && imemAck_i;
    // New request only once the previous ack has been seen low
    assign raise   = !reqQ && !imemAck_i;
    assign pcNext  = redirect_i ? redirectPc_i : pcQ;

    assign imemReq_o  = reqQ;
    assign imemAddr_o = addrQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            reqQ         <= 1'b0;
            discardQ     <= 1'b0;
            pcQ          <= corePkg::resetPc;
            addrQ        <= corePkg::resetPc;
            instrValid_o <= 1'b0;
        end else begin
            instrValid_o <= capture && !discardQ && !redirect_i;

            if (capture) begin
                reqQ <= 1'b0;
            end else if (raise) begin
                reqQ  <= 1'b1;
                addrQ <= pcNext;
            end

            // Wrong-path fetch still in flight, finish it and drop the word
            if (capture) begin
                discardQ <= 1'b0;
            end else if (reqQ && redirect_i) begin
                discardQ <= 1'b1;
            end

            if (redirect_i) begin
                pcQ <= redirectPc_i;
            end else if (capture && !discardQ) begin
                pcQ <= pcQ + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instr_o   <= imemInstr_i;
            instrPc_o <= addrQ;
        end
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// Register file
// x1..x31 with two combinational reads, x0 reads zero, writes pass through to reads
`default_nettype none

module regFile (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [corePkg::regAddrW-1:0] rs1_i,
    input  logic [corePkg::regAddrW-1:0] rs2_i,
    input  logic [corePkg::regAddrW-1:0] rd_i,
    input  logic                         we_i,
    input  logic [corePkg::xlen-1:0]     wd_i,
    output logic [corePkg::xlen-1:0]     rs1Data_o,
    output logic [corePkg::xlen-1:0]     rs2Data_o
);

    logic [corePkg::xlen-1:0] regs [1:31];

    function automatic logic [corePkg::xlen-1:0] readPort(
        input logic [corePkg::regAddrW-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        // Same-cycle write from writeback wins
        if (we_i && addr == rd_i) begin
            return wd_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

    always_comb begin
        rs1Data_o = readPort(rs1_i);
        rs2Data_o = readPort(rs2_i);
    end

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
// Decode stage
// Field extraction, control decode, immediate build and register read
`default_nettype none

module decodeStage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [corePkg::xlen-1:0]     instr_i,
    input  logic [corePkg::xlen-1:0]     pc_i,
    input  logic [corePkg::regAddrW-1:0] wbRd_i,
    input  logic                         wbWe_i,
    input  logic [corePkg::xlen-1:0]     wbData_i,
    output corePkg::exPayloadT           payload_o
);

    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic                         funct7b5;
    logic [corePkg::regAddrW-1:0] rs1;
    logic [corePkg::regAddrW-1:0] rs2;
    logic [corePkg::regAddrW-1:0] rd;
    logic [corePkg::xlen-1:0]     imm;
    logic [corePkg::xlen-1:0]     rs1Val;
    logic [corePkg::xlen-1:0]     rs2Val;
    corePkg::deCtrlT              ctrl;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7b5 = instr_i[30];
    assign rd       = instr_i[11:7];
    assign rs2      = instr_i[24:20];
    // lui holds immediate bits here, reading x0 turns the add into a pass of imm
    assign rs1      = (opcode == corePkg::opLui) ? '0 : instr_i[19:15];

    always_comb begin
        ctrl = '0;
        case (opcode)
            corePkg::opR: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    corePkg::f3Add: ctrl.aluOp = funct7b5 ? corePkg::aluSub : corePkg::aluAdd;
                    corePkg::f3Slt: ctrl.aluOp = corePkg::aluSlt;
                    corePkg::f3Xor: ctrl.aluOp = corePkg::aluXor;
                    corePkg::f3Or:  ctrl.aluOp = corePkg::aluOr;
                    corePkg::f3And: ctrl.aluOp = corePkg::aluAnd;
                    default:        ctrl.regWrite = 1'b0;
                endcase
            end
            corePkg::opImm: begin
                // addi only
                ctrl.regWrite = (funct3 == corePkg::f3Add);
                ctrl.useImm   = 1'b1;
            end
            corePkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
            end
            corePkg::opBranch: begin
                ctrl.isBranch = (funct3 == corePkg::f3Beq) || (funct3 == corePkg::f3Bne);
                ctrl.branchNe = (funct3 == corePkg::f3Bne);
                ctrl.aluOp    = corePkg::aluSub;
            end
            corePkg::opJal: begin
                ctrl.regWrite     = 1'b1;
                ctrl.isJal        = 1'b1;
                ctrl.resultIsLink = 1'b1;
            end
            // Anything else stays a no-op
            default: ;
        endcase
        if (rd == '0) begin
            ctrl.regWrite = 1'b0;
        end
    end

    always_comb begin
        case (opcode)
            corePkg::opBranch: begin
                imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            corePkg::opJal: begin
                imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            corePkg::opLui: imm = {instr_i[31:12], 12'b0};
            default:        imm = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

    regFile rf (
        .clk       (clk),
        .reset     (reset),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rd_i      (wbRd_i),
        .we_i      (wbWe_i),
        .wd_i      (wbData_i),
        .rs1Data_o (rs1Val),
        .rs2Data_o (rs2Val)
    );

    always_comb begin
        payload_o.pc     = pc_i;
        payload_o.rs1Val = rs1Val;
        payload_o.rs2Val = rs2Val;
        payload_o.imm    = imm;
        payload_o.rs1    = rs1;
        payload_o.rs2    = rs2;
        payload_o.rd     = rd;
        payload_o.ctrl   = ctrl;
    end

endmodule

`default_nettype wire

/* rtl/forwardUnit.sv */
// Forwarding unit
// Picks the newest in-flight producer for each execute operand
`default_nettype none

module forwardUnit (
    input  logic [corePkg::regAddrW-1:0] exRs1_i,
    input  logic [corePkg::regAddrW-1:0] exRs2_i,
    input  logic [corePkg::regAddrW-1:0] memRd_i,
    input  logic                         memWe_i,
    input  logic                         memValid_i,
    input  logic [corePkg::regAddrW-1:0] wbRd_i,
    input  logic                         wbWe_i,
    input  logic                         wbValid_i,
    output corePkg::fwdSelT              fwdA_o,
    output corePkg::fwdSelT              fwdB_o
);

    logic memHit;
    logic wbHit;

    assign memHit = memValid_i && memWe_i && (memRd_i != '0);
    assign wbHit  = wbValid_i && wbWe_i && (wbRd_i != '0);

    // Memory stage holds the younger value
    function automatic corePkg::fwdSelT pickSrc(input logic [corePkg::regAddrW-1:0] rs);
        if (memHit && memRd_i == rs) begin
            return corePkg::fwdMem;
        end
        if (wbHit && wbRd_i == rs) begin
            return corePkg::fwdWb;
        end
        return corePkg::fwdReg;
    endfunction

    always_comb begin
        fwdA_o = pickSrc(exRs1_i);
        fwdB_o = pickSrc(exRs2_i);
    end

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
// Execute stage
// Operand forwarding, ALU, branch and jal resolution, writeback payload
`default_nettype none

module executeStage (
    input  corePkg::exPayloadT       ex_i,
    input  logic                     exValid_i,
    input  corePkg::fwdSelT          fwdA_i,
    input  corePkg::fwdSelT          fwdB_i,
    input  logic [corePkg::xlen-1:0] memResult_i,
    input  logic [corePkg::xlen-1:0] wbResult_i,
    output logic                     redirect_o,
    output logic [corePkg::xlen-1:0] redirectPc_o,
    output corePkg::wbPayloadT       wb_o
);

    logic [corePkg::xlen-1:0] opA;
    logic [corePkg::xlen-1:0] opB;
    logic [corePkg::xlen-1:0] srcB;
    logic [corePkg::xlen-1:0] aluOut;
    logic                     equal;
    logic                     taken;

    function automatic logic [corePkg::xlen-1:0] fwdMux(
        input corePkg::fwdSelT          sel,
        input logic [corePkg::xlen-1:0] regVal
    );
        case (sel)
            corePkg::fwdMem: return memResult_i;
            corePkg::fwdWb:  return wbResult_i;
            default:         return regVal;
        endcase
    endfunction

    always_comb begin
        opA = fwdMux(fwdA_i, ex_i.rs1Val);
        opB = fwdMux(fwdB_i, ex_i.rs2Val);
    end

    assign srcB = ex_i.ctrl.useImm ? ex_i.imm : opB;

    always_comb begin
        case (ex_i.ctrl.aluOp)
            corePkg::aluSub: aluOut = opA - srcB;
            corePkg::aluAnd: aluOut = opA & srcB;
            corePkg::aluOr:  aluOut = opA | srcB;
            corePkg::aluXor: aluOut = opA ^ srcB;
            corePkg::aluSlt: aluOut = {{(corePkg::xlen-1){1'b0}}, $signed(opA) < $signed(srcB)};
            default:         aluOut = opA + srcB;
        endcase
    end

    // Branches compare the two register operands
    assign equal = (opA == opB);
    assign taken = ex_i.ctrl.isJal || (ex_i.ctrl.isBranch && (equal ^ ex_i.ctrl.branchNe));

    // Any taken transfer redirects since fetch predicts not-taken
    assign redirect_o   = exValid_i && taken;
    assign redirectPc_o = ex_i.pc + ex_i.imm;

    always_comb begin
        wb_o.pc       = ex_i.pc;
        wb_o.rd       = ex_i.rd;
        wb_o.regWrite = ex_i.ctrl.regWrite;
        wb_o.result   = ex_i.ctrl.resultIsLink ? ex_i.pc + 32'd4 : aluOut;
    end

endmodule

`default_nettype wire

/* rtl/pipelineCore.sv */
// Pipelined core top level
// Fetch, decode, execute, memory and writeback with a retire trace port
`default_nettype none

module pipelineCore (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         imemAck_i,
    input  logic [corePkg::xlen-1:0]     imemInstr_i,
    output logic                         imemReq_o,
    output logic [corePkg::xlen-1:0]     imemAddr_o,
    output logic                         retireValid_o,
    output logic [corePkg::xlen-1:0]     retirePc_o,
    output logic [corePkg::regAddrW-1:0] retireRd_o,
    output logic                         retireWe_o,
    output logic [corePkg::xlen-1:0]     retireData_o
);

    logic                     fdValid;
    logic [corePkg::xlen-1:0] fdInstr;
    logic [corePkg::xlen-1:0] fdPc;
    logic                     redirect;
    logic [corePkg::xlen-1:0] redirectPc;
    corePkg::exPayloadT       dePayload;
    logic                     exValid;
    corePkg::exPayloadT       exData;
    corePkg::fwdSelT          fwdA;
    corePkg::fwdSelT          fwdB;
    corePkg::wbPayloadT       exResult;
    logic                     memValid;
    corePkg::wbPayloadT       memData;
    logic                     wbValid;
    corePkg::wbPayloadT       wbData;
    logic                     wbWe;

    assign wbWe = wbValid && wbData.regWrite;

    fetchStage fetch (
        .clk          (clk),
        .reset        (reset),
        .imemAck_i    (imemAck_i),
        .imemInstr_i  (imemInstr_i),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .imemReq_o    (imemReq_o),
        .imemAddr_o   (imemAddr_o),
        .instrValid_o (fdValid),
        .instr_o      (fdInstr),
        .instrPc_o    (fdPc)
    );

    decodeStage decode (
        .clk       (clk),
        .reset     (reset),
        .instr_i   (fdInstr),
        .pc_i      (fdPc),
        .wbRd_i    (wbData.rd),
        .wbWe_i    (wbWe),
        .wbData_i  (wbData.result),
        .payload_o (dePayload)
    );

    // Redirect squashes the instruction now leaving decode
    pipeReg #(.payloadT(corePkg::exPayloadT)) deExReg (
        .clk     (clk),
        .reset   (reset),
        .flush_i (redirect),
        .valid_i (fdValid),
        .data_i  (dePayload),
        .valid_o (exValid),
        .data_o  (exData)
    );

    forwardUnit fwd (
        .exRs1_i    (exData.rs1),
        .exRs2_i    (exData.rs2),
        .memRd_i    (memData.rd),
        .memWe_i    (memData.regWrite),
        .memValid_i (memValid),
        .wbRd_i     (wbData.rd),
        .wbWe_i     (wbData.regWrite),
        .wbValid_i  (wbValid),
        .fwdA_o     (fwdA),
        .fwdB_o     (fwdB)
    );

    executeStage execute (
        .ex_i         (exData),
        .exValid_i    (exValid),
        .fwdA_i       (fwdA),
        .fwdB_i       (fwdB),
        .memResult_i  (memData.result),
        .wbResult_i   (wbData.result),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .wb_o         (exResult)
    );

    pipeReg #(.payloadT(corePkg::wbPayloadT)) exMemReg (
        .clk     (clk),
        .reset   (reset),
        .flush_i (1'b0),
        .valid_i (exValid),
        .data_i  (exResult),
        .valid_o (memValid),
        .data_o  (memData)
    );

    // No data memory, the memory stage only adds latency
    pipeReg #(.payloadT(corePkg::wbPayloadT)) memWbReg (
        .clk     (clk),
        .reset   (reset),
        .flush_i (1'b0),
        .valid_i (memValid),
        .data_i  (memData),
        .valid_o (wbValid),
        .data_o  (wbData)
    );

    assign retireValid_o = wbValid;
    assign retirePc_o    = wbData.pc;
    assign retireRd_o    = wbData.rd;
    assign retireWe_o    = wbData.regWrite;
    assign retireData_o  = wbData.result;

endmodule

`default_nettype wire

/* testbench/pipelineCore_assertions.sv */
// Core protocol checker
// Fetch handshake, reset and retire port properties, bound into pipelineCore
`default_nettype none

module pipelineCore_assertions (
    input logic                         clk,
    input logic                         reset,
    input logic                         imemReq_i,
    input logic                         imemAck_i,
    input logic [corePkg::xlen-1:0]     imemAddr_i,
    input logic                         retireValid_i,
    input logic                         retireWe_i,
    input logic [corePkg::regAddrW-1:0] retireRd_i,
    input logic [corePkg::xlen-1:0]     retireData_i
);

    int   failCount = 0;
    logic inReset   = 1'b0;
    logic reqSeen   = 1'b0;

    // inReset is high once reset has been seen on a previous edge
    always @(posedge clk) begin
        inReset <= reset;
        if (reset) begin
            reqSeen <= 1'b0;
        end else if (imemReq_i) begin
            reqSeen <= 1'b1;
        end
    end

    resetQuiet: assert property (@(posedge clk)
        reset && inReset |-> !imemReq_i && !retireValid_i)
        else begin
            failCount++;
            $error("request or retire active during reset");
        end

    firstAddr: assert property (@(posedge clk) disable iff (reset)
        imemReq_i && !reqSeen |-> imemAddr_i == corePkg::resetPc)
        else begin
            failCount++;
            $error("first fetch address is not the reset pc");
        end

    // Request is held until the memory answers
    reqHeld: assert property (@(posedge clk) disable iff (reset)
        imemReq_i && !imemAck_i |=> imemReq_i)
        else begin
            failCount++;
            $error("request dropped before ack");
        end

    addrStable: assert property (@(posedge clk) disable iff (reset)
        imemReq_i && !imemAck_i |=> $stable(imemAddr_i))
        else begin
            failCount++;
            $error("fetch address changed while request was high");
        end

    reqDrop: assert property (@(posedge clk) disable iff (reset)
        imemReq_i && imemAck_i |=> !imemReq_i)
        else begin
            failCount++;
            $error("request not dropped on capture edge");
        end

    noRaiseUnderAck: assert property (@(posedge clk) disable iff (reset)
        !imemReq_i && imemAck_i |=> !imemReq_i)
        else begin
            failCount++;
            $error("request raised while ack still high");
        end

    noX0Write: assert property (@(posedge clk) disable iff (reset)
        retireValid_i && retireWe_i |-> retireRd_i != '0)
        else begin
            failCount++;
            $error("retired write to x0");
        end

    retireKnown: assert property (@(posedge clk) disable iff (reset)
        retireValid_i |-> !$isunknown({retireWe_i, retireRd_i, retireData_i}))
        else begin
            failCount++;
            $error("unknown value on retire port");
        end

endmodule

`default_nettype wire

/* testbench/coreTb.sv */
// Core testbench
// Instruction memory with random ack delay, ISA reference model and retire checks
`default_nettype none

module coreTb;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 8;
    localparam int progWords   = 33;
    localparam logic [31:0] haltPc = 32'd128;
    // Dynamic instruction bound and worst handshake length in cycles
    localparam int dynBound    = 40;
    localparam int worstFetch  = 8;
    // A taken transfer can waste one fetch
    // Doubled again for margin
    localparam int timeoutCycles = resetCycles + 2 * dynBound * 2 * worstFetch;

    logic                         clk;
    logic                         reset;
    logic                         imemAck;
    logic [corePkg::xlen-1:0]     imemInstr;
    logic                         imemReq;
    logic [corePkg::xlen-1:0]     imemAddr;
    logic                         retireValid;
    logic [corePkg::xlen-1:0]     retirePc;
    logic [corePkg::regAddrW-1:0] retireRd;
    logic                         retireWe;
    logic [corePkg::xlen-1:0]     retireData;

    logic [31:0] imem [0:progWords-1];
    logic [31:0] shadow [0:31];
    logic [31:0] modelPc;
    int unsigned lcgState      = 55014;
    int          mismatchCount = 0;
    int          timeouts      = 0;
    int          retireCount   = 0;
    logic        haltRetired   = 1'b0;
    logic        pending       = 1'b0;
    int          delayLeft     = 0;

    pipelineCore uut (
        .clk           (clk),
        .reset         (reset),
        .imemAck_i     (imemAck),
        .imemInstr_i   (imemInstr),
        .imemReq_o     (imemReq),
        .imemAddr_o    (imemAddr),
        .retireValid_o (retireValid),
        .retirePc_o    (retirePc),
        .retireRd_o    (retireRd),
        .retireWe_o    (retireWe),
        .retireData_o  (retireData)
    );

    bind pipelineCore pipelineCore_assertions sva (
        .clk           (clk),
        .reset         (reset),
        .imemReq_i     (imemReq_o),
        .imemAck_i     (imemAck_i),
        .imemAddr_i    (imemAddr_o),
        .retireValid_i (retireValid_o),
        .retireWe_i    (retireWe_o),
        .retireRd_i    (retireRd_o),
        .retireData_i  (retireData_o)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    function automatic logic [31:0] aluWord(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, corePkg::opR};
    endfunction

    function automatic logic [31:0] addiWord(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, corePkg::f3Add, rd, corePkg::opImm};
    endfunction

    function automatic logic [31:0] luiWord(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, corePkg::opLui};
    endfunction

    function automatic logic [31:0] branchWord(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], corePkg::opBranch};
    endfunction

    function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, corePkg::opJal};
    endfunction

    // Custom-0 no-ops tagged with the address fill the space outside the program
    function automatic logic [31:0] readWord(input logic [31:0] addr);
        if (addr[1:0] == 2'b00 && addr < progWords * 4) begin
            return imem[addr >> 2];
        end
        return {addr[31:7] ^ addr[24:0], 7'b0001011};
    endfunction

    task automatic loadProgram();
        imem[0]  = addiWord(5'd1, 5'd0, 12'd5);
        imem[1]  = addiWord(5'd2, 5'd1, 12'hFFD);
        imem[2]  = aluWord(7'h00, corePkg::f3Add, 5'd3, 5'd1, 5'd2);
        imem[3]  = aluWord(7'h20, corePkg::f3Add, 5'd4, 5'd2, 5'd3);
        imem[4]  = aluWord(7'h00, corePkg::f3Slt, 5'd5, 5'd4, 5'd2);
        imem[5]  = aluWord(7'h00, corePkg::f3Slt, 5'd6, 5'd2, 5'd4);
        imem[6]  = aluWord(7'h00, corePkg::f3Xor, 5'd7, 5'd4, 5'd3);
        imem[7]  = aluWord(7'h00, corePkg::f3Or, 5'd8, 5'd7, 5'd1);
        imem[8]  = aluWord(7'h00, corePkg::f3And, 5'd9, 5'd8, 5'd4);
        imem[9]  = luiWord(5'd10, 20'hABCDE);
        imem[10] = addiWord(5'd10, 5'd10, 12'hFFF);
        // Write to x0, then read it back
        imem[11] = addiWord(5'd0, 5'd1, 12'd7);
        imem[12] = aluWord(7'h00, corePkg::f3Add, 5'd11, 5'd0, 5'd1);
        imem[13] = branchWord(corePkg::f3Beq, 5'd1, 5'd2, 13'd8);
        imem[14] = branchWord(corePkg::f3Bne, 5'd1, 5'd2, 13'd8);
        imem[15] = addiWord(5'd12, 5'd0, 12'd99);
        // Countdown loop of three passes
        imem[16] = addiWord(5'd13, 5'd0, 12'd3);
        imem[17] = addiWord(5'd14, 5'd14, 12'd2);
        imem[18] = addiWord(5'd13, 5'd13, 12'hFFF);
        imem[19] = branchWord(corePkg::f3Bne, 5'd13, 5'd0, 13'h1FF8);
        imem[20] = branchWord(corePkg::f3Beq, 5'd14, 5'd14, 13'd12);
        imem[21] = addiWord(5'd15, 5'd0, 12'd1);
        imem[22] = addiWord(5'd15, 5'd0, 12'd2);
        imem[23] = jalWord(5'd16, 21'd12);
        imem[24] = addiWord(5'd17, 5'd0, 12'd1);
        imem[25] = addiWord(5'd17, 5'd0, 12'd2);
        imem[26] = 32'h0000_500B;
        imem[27] = jalWord(5'd0, 21'd8);
        imem[28] = addiWord(5'd18, 5'd0, 12'd1);
        imem[29] = aluWord(7'h00, corePkg::f3Slt, 5'd19, 5'd10, 5'd0);
        imem[30] = aluWord(7'h00, corePkg::f3Add, 5'd20, 5'd16, 5'd19);
        imem[31] = aluWord(7'h00, corePkg::f3Slt, 5'd21, 5'd10, 5'd4);
        imem[32] = jalWord(5'd0, 21'd0);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            mismatchCount++;
            $display("mismatch at time %0t: %s is %h, expected %h (pc %h)",
                     $time, what, got, exp, modelPc);
        end
    endtask

    // One ISA step of the reference model per retired instruction
    task automatic checkRetire();
        logic [31:0] instr;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] expData;
        logic [31:0] nextPc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        writes;
        logic        expWe;
        instr   = readWord(modelPc);
        rd      = instr[11:7];
        f3      = instr[14:12];
        rs1v    = shadow[instr[19:15]];
        rs2v    = shadow[instr[24:20]];
        nextPc  = modelPc + 32'd4;
        writes  = 1'b0;
        expData = '0;
        case (instr[6:0])
            corePkg::opR: begin
                writes = 1'b1;
                case (f3)
                    3'b000:  expData = instr[30] ? rs1v - rs2v : rs1v + rs2v;
                    3'b010:  expData = ($signed(rs1v) < $signed(rs2v)) ? 32'd1 : 32'd0;
                    3'b100:  expData = rs1v ^ rs2v;
                    3'b110:  expData = rs1v | rs2v;
                    3'b111:  expData = rs1v & rs2v;
                    default: writes = 1'b0;
                endcase
            end
            corePkg::opImm: begin
                writes  = (f3 == 3'b000);
                expData = rs1v + {{20{instr[31]}}, instr[31:20]};
            end
            corePkg::opLui: begin
                writes  = 1'b1;
                expData = {instr[31:12], 12'b0};
            end
            corePkg::opBranch: begin
                if ((f3 == 3'b000 && rs1v == rs2v) || (f3 == 3'b001 && rs1v != rs2v)) begin
                    nextPc = modelPc + {{20{instr[31]}}, instr[7], instr[30:25],
                                        instr[11:8], 1'b0};
                end
            end
            corePkg::opJal: begin
                writes  = 1'b1;
                expData = modelPc + 32'd4;
                nextPc  = modelPc + {{12{instr[31]}}, instr[19:12], instr[20],
                                     instr[30:21], 1'b0};
            end
            default: ;
        endcase
        expWe = writes && (rd != 5'd0);
        checkValue("retire pc", retirePc, modelPc);
        checkValue("retire we", {31'b0, retireWe}, {31'b0, expWe});
        if (expWe) begin
            checkValue("retire rd", {27'b0, retireRd}, {27'b0, rd});
            checkValue("retire data", retireData, expData);
            shadow[rd] = expData;
        end
        retireCount++;
        if (modelPc == haltPc) begin
            haltRetired = 1'b1;
        end
        modelPc = nextPc;
    endtask

    task automatic finishRun();
        int assertFails;
        assertFails = uut.sva.failCount;
        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts, %0d retired",
                 mismatchCount, assertFails, timeouts, retireCount);
        if (mismatchCount == 0 && assertFails == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Ack follows req by 0 to 3 cycles and is released 0 to 3 cycles after req falls
    always @(negedge clk) begin
        if (imemAck) begin
            if (!imemReq) begin
                if (!pending) begin
                    pending   = 1'b1;
                    delayLeft = nextRand() % 4;
                end
                if (delayLeft == 0) begin
                    imemAck = 1'b0;
                    pending = 1'b0;
                end else begin
                    delayLeft--;
                end
            end
        end else if (imemReq) begin
            if (!pending) begin
                pending   = 1'b1;
                delayLeft = nextRand() % 4;
            end
            if (delayLeft == 0) begin
                imemAck   = 1'b1;
                imemInstr = readWord(imemAddr);
                pending   = 1'b0;
            end else begin
                delayLeft--;
            end
        end
    end

    always @(negedge clk) begin
        if (retireValid) begin
            checkRetire();
        end
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        imemAck   = 1'b0;
        imemInstr = '0;
        loadProgram();
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        modelPc = corePkg::resetPc;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        wait (haltRetired);
        repeat (4) @(negedge clk);
        finishRun();
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: halt instruction did not retire within %0d cycles", timeoutCycles);
        timeouts++;
        finishRun();
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/corePkg.sv
rtl/pipeReg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/forwardUnit.sv
rtl/executeStage.sv
rtl/pipelineCore.sv
testbench/pipelineCore_assertions.sv
testbench/coreTb.sv
